// ==== Makefile ====
# Verilator build of the interrupt block testbench
# the simulator binary is rebuilt only when the file list or a source changes

SIM := obj_dir/Vglb_intr_tb
SRCS := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module glb_intr_tb -f build.f

# run from the project root, the vector file path is relative to it
# the exit status of the simulator is the test result
run: $(SIM) tests/glb_intr_vectors.txt
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+hdl
hdl/glb_intr_pkg.sv
hdl/glb_intr_bank.sv
hdl/glb_intr_combiner.sv
hdl/glb_intr_top.sv
tests/glb_intr_tb.sv

// ==== hdl/glb_intr_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BITS must not exceed the config data width
// event pulses are single cycle and sampled every clk
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "glb_intr_macros.svh"

`default_nettype none

module glb_intr_bank #(
    parameter int BITS = `GLB_NUM_TILES,
    parameter glb_intr_pkg::cfg_reg_e IER_REG = glb_intr_pkg::reg_ier_pcfg,
    parameter glb_intr_pkg::cfg_reg_e ISR_REG = glb_intr_pkg::reg_isr_pcfg
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  glb_intr_pkg::cfg_addr_t  wr_addr,
    input  glb_intr_pkg::cfg_data_t  wr_data,
    input  logic [BITS-1:0]          event_pulse,
    output logic [BITS-1:0]          ier,
    output logic [BITS-1:0]          isr
);

    // register selected by the write address
    glb_intr_pkg::cfg_reg_e wr_reg;
    // write strobes for this bank only
    logic ier_wr;
    logic isr_wr;
    // per-bit set and toggle requests
    logic [BITS-1:0] set_vec;
    logic [BITS-1:0] tog_vec;

    // whole field has to fit in one data word
    if (BITS > `GLB_CFG_DATA_WIDTH) begin : g_bits_check
        $error("glb_intr_bank: BITS exceeds config data width");
    end

    // the other bank's addresses fall through as no-ops here
    assign wr_reg = glb_intr_pkg::decode_cfg_addr(wr_addr);
    assign ier_wr = wr_en && (wr_reg == IER_REG);
    assign isr_wr = wr_en && (wr_reg == ISR_REG);

    // an event only counts while its enable is already set
    assign set_vec = ier & event_pulse;
    // ones in the written word flip the status bit
    assign tog_vec = isr_wr ? wr_data[BITS-1:0] : '0;

    // enable register
    // new value visible from the write edge on
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ier <= '0;
        end else if (ier_wr) begin
            // upper data bits are ignored
            ier <= wr_data[BITS-1:0];
        end
    end

    // status register
    // set wins over a toggle of the same bit in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            isr <= '0;
        end else begin
            isr <= set_vec | (isr ^ tog_vec);
        end
    end

    // a status bit only comes up from its enabled event
    // or from software writing a one into a clear bit
    for (genvar i = 0; i < BITS; i++) begin : g_isr_rise_chk
        isr_rise_a: assert property (
            @(posedge clk) disable iff (reset)
            $rose(isr[i]) |->
                ($past(ier[i] && event_pulse[i]) || $past(isr_wr && wr_data[i]))
        )
        else $error("isr[%0d] rose without an enabled event or toggle", i);
    end

    // nothing survives reset
    reset_clear_a: assert property (
        @(posedge clk)
        reset |-> ((ier == '0) && (isr == '0))
    )
    else $error("bank registers not cleared by reset");

endmodule

`default_nettype wire

// ==== hdl/glb_intr_combiner.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read data is registered, valid one cycle after rd_en
// no back-pressure, every read returns exactly once
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "glb_intr_macros.svh"

`default_nettype none

module glb_intr_combiner (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rd_en,
    input  glb_intr_pkg::cfg_addr_t         rd_addr,
    input  logic [2*`GLB_NUM_TILES-1:0]     dma_ier,
    input  logic [2*`GLB_NUM_TILES-1:0]     dma_isr,
    input  logic [`GLB_NUM_TILES-1:0]       pcfg_ier,
    input  logic [`GLB_NUM_TILES-1:0]       pcfg_isr,
    output glb_intr_pkg::cfg_data_t         rd_data,
    output logic                            rd_data_valid,
    output logic                            interrupt
);

    // decoded read select
    glb_intr_pkg::cfg_reg_e rd_reg;
    // field picked for this cycle's read, zero-extended
    glb_intr_pkg::cfg_data_t rd_field;

    assign rd_reg = glb_intr_pkg::decode_cfg_addr(rd_addr);

    // read mux
    // values are the ones held before the edge, so a
    // write or pulse in the same cycle is not visible yet
    always_comb begin
        case (rd_reg)
            glb_intr_pkg::reg_ier_dma:  rd_field = glb_intr_pkg::cfg_data_t'(dma_ier);
            glb_intr_pkg::reg_isr_dma:  rd_field = glb_intr_pkg::cfg_data_t'(dma_isr);
            glb_intr_pkg::reg_ier_pcfg: rd_field = glb_intr_pkg::cfg_data_t'(pcfg_ier);
            glb_intr_pkg::reg_isr_pcfg: rd_field = glb_intr_pkg::cfg_data_t'(pcfg_isr);
            // unknown address reads as zero, still valid
            default:                    rd_field = '0;
        endcase
    end

    // read pipeline, one stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data       <= '0;
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
            // data holds between reads
            if (rd_en) begin
                rd_data <= rd_field;
            end
        end
    end

    // level interrupt, any status bit of either bank
    assign interrupt = (|dma_isr) | (|pcfg_isr);

    // one valid cycle per accepted read, back-to-back allowed
    rd_valid_follow_a: assert property (
        @(posedge clk) disable iff (reset)
        1'b1 |=> (rd_data_valid == $past(rd_en))
    )
    else $error("rd_data_valid does not track rd_en by one cycle");

    // no spurious interrupt with both banks idle
    intr_needs_status_a: assert property (
        @(posedge clk) disable iff (reset)
        interrupt |-> ((dma_isr != '0) || (pcfg_isr != '0))
    )
    else $error("interrupt high with no status bit set");

endmodule

`default_nettype wire

// ==== hdl/glb_intr_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile count must stay in 1..16 so the dma field (2N) fits the data word
// register addresses are byte addresses, word aligned
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef GLB_INTR_MACROS_SVH
`define GLB_INTR_MACROS_SVH

// number of tiles behind the global buffer
`define GLB_NUM_TILES 8

// config strobe bus widths
`define GLB_CFG_ADDR_WIDTH 12
`define GLB_CFG_DATA_WIDTH 32

// register map
// dma enable, one bit per store/load event
`define GLB_ADDR_IER_DMA 'h00
// dma status, write one to toggle
`define GLB_ADDR_ISR_DMA 'h04
// config controller enable
`define GLB_ADDR_IER_PCFG 'h08
// config controller status, write one to toggle
`define GLB_ADDR_ISR_PCFG 'h0C

// dma field layout inside the 2N wide vectors
// bits 0..N-1 store, bits N..2N-1 load

`endif

// ==== hdl/glb_intr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register decode for the interrupt block
// addresses outside the map decode to reg_none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "glb_intr_macros.svh"

`default_nettype none

package glb_intr_pkg;

    // register select, the opcode of a strobe access
    typedef enum logic [2:0] {
        reg_ier_dma,
        reg_isr_dma,
        reg_ier_pcfg,
        reg_isr_pcfg,
        reg_none
    } cfg_reg_e;

    // strobe bus payload types
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_data_t;

    // map a byte address onto a register
    // shared by the write side (banks) and the read side (combiner)
    function automatic cfg_reg_e decode_cfg_addr(input cfg_addr_t addr);
        cfg_reg_e sel;
        case (addr)
            `GLB_ADDR_IER_DMA:  sel = reg_ier_dma;
            `GLB_ADDR_ISR_DMA:  sel = reg_isr_dma;
            `GLB_ADDR_IER_PCFG: sel = reg_ier_pcfg;
            `GLB_ADDR_ISR_PCFG: sel = reg_isr_pcfg;
            // unmapped, including unaligned
            default:            sel = reg_none;
        endcase
        return sel;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/glb_intr_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pulse bundle: store [N-1:0], load [2N-1:N], pcfg [3N-1:2N]
// single clock domain, async active-high reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "glb_intr_macros.svh"

`default_nettype none

module glb_intr_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wr_en,
    input  glb_intr_pkg::cfg_addr_t         wr_addr,
    input  glb_intr_pkg::cfg_data_t         wr_data,
    input  logic                            rd_en,
    input  glb_intr_pkg::cfg_addr_t         rd_addr,
    input  logic [3*`GLB_NUM_TILES-1:0]     event_pulse_bundle,
    output glb_intr_pkg::cfg_data_t         rd_data,
    output logic                            rd_data_valid,
    output logic                            interrupt
);

    localparam int NT = `GLB_NUM_TILES;

    // bank outputs into the combiner
    logic [2*NT-1:0] dma_ier;
    logic [2*NT-1:0] dma_isr;
    logic [NT-1:0]   pcfg_ier;
    logic [NT-1:0]   pcfg_isr;

    // store and load dma events, low 2N bits
    glb_intr_bank #(
        .BITS    (2*NT),
        .IER_REG (glb_intr_pkg::reg_ier_dma),
        .ISR_REG (glb_intr_pkg::reg_isr_dma)
    ) dma_bank_i (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .event_pulse (event_pulse_bundle[2*NT-1:0]),
        .ier         (dma_ier),
        .isr         (dma_isr)
    );

    // parallel-config controller events, high N bits
    glb_intr_bank #(
        .BITS    (NT),
        .IER_REG (glb_intr_pkg::reg_ier_pcfg),
        .ISR_REG (glb_intr_pkg::reg_isr_pcfg)
    ) pcfg_bank_i (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .event_pulse (event_pulse_bundle[3*NT-1:2*NT]),
        .ier         (pcfg_ier),
        .isr         (pcfg_isr)
    );

    // read side and interrupt line
    glb_intr_combiner combiner_i (
        .clk           (clk),
        .reset         (reset),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .dma_ier       (dma_ier),
        .dma_isr       (dma_isr),
        .pcfg_ier      (pcfg_ier),
        .pcfg_isr      (pcfg_isr),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .interrupt     (interrupt)
    );

endmodule

`default_nettype wire

// ==== tests/glb_intr_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run from the project root, vectors come from tests/
// stops at the first mismatch or missing read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "glb_intr_macros.svh"

`default_nettype none

module glb_intr_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = `GLB_NUM_TILES;
    // cycles allowed for a read to come back
    localparam int READ_TIMEOUT = 8;
    localparam int RANDOM_CYCLES = 2000;

    // register map, as the model sees it
    localparam glb_intr_pkg::cfg_addr_t ADDR_IER_DMA = `GLB_ADDR_IER_DMA;
    localparam glb_intr_pkg::cfg_addr_t ADDR_ISR_DMA = `GLB_ADDR_ISR_DMA;
    localparam glb_intr_pkg::cfg_addr_t ADDR_IER_PCFG = `GLB_ADDR_IER_PCFG;
    localparam glb_intr_pkg::cfg_addr_t ADDR_ISR_PCFG = `GLB_ADDR_ISR_PCFG;

    // dut ports
    logic clk;
    logic reset;
    logic wr_en;
    glb_intr_pkg::cfg_addr_t wr_addr;
    glb_intr_pkg::cfg_data_t wr_data;
    logic rd_en;
    glb_intr_pkg::cfg_addr_t rd_addr;
    logic [3*N-1:0] event_pulse_bundle;
    glb_intr_pkg::cfg_data_t rd_data;
    logic rd_data_valid;
    logic interrupt;

    // software copy of the four registers
    logic [2*N-1:0] m_ier_dma;
    logic [2*N-1:0] m_isr_dma;
    logic [N-1:0] m_ier_pcfg;
    logic [N-1:0] m_isr_pcfg;
    // expected data of reads in flight
    glb_intr_pkg::cfg_data_t exp_reads[$];

    // inputs driven at the last rising edge
    logic cur_wr_en;
    glb_intr_pkg::cfg_addr_t cur_wr_addr;
    glb_intr_pkg::cfg_data_t cur_wr_data;
    logic cur_rd_en;
    glb_intr_pkg::cfg_addr_t cur_rd_addr;
    logic [3*N-1:0] cur_pulse;

    logic [31:0] lcg_state;

    glb_intr_top dut_i (
        .clk                (clk),
        .reset              (reset),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .event_pulse_bundle (event_pulse_bundle),
        .rd_data            (rd_data),
        .rd_data_valid      (rd_data_valid),
        .interrupt          (interrupt)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // numerical recipes lcg
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic end_in_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rd_data(input glb_intr_pkg::cfg_data_t expected,
                                 input glb_intr_pkg::cfg_data_t actual);
        if (actual !== expected) begin
            $display("FAILED rd_data: expected 0x%h, actual 0x%h", expected, actual);
            end_in_failure();
        end
    endtask

    task automatic check_interrupt(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED interrupt: expected 0x%h, actual 0x%h", expected, actual);
            end_in_failure();
        end
    endtask

    task automatic check_read_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED rd_data_valid: expected 0x%h, actual 0x%h", expected, actual);
            end_in_failure();
        end
    endtask

    task automatic drive_idle();
        wr_en <= 1'b0;
        wr_addr <= '0;
        wr_data <= '0;
        rd_en <= 1'b0;
        rd_addr <= '0;
        event_pulse_bundle <= '0;
    endtask

    // reset is already high on entry
    task automatic hold_reset();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    endtask

    // wait for the read strobe, sampled mid-cycle
    task automatic wait_read_data(output glb_intr_pkg::cfg_data_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (rd_data_valid !== 1'b1) begin
            waited++;
            if (waited > READ_TIMEOUT) begin
                $display("no read data came back within %0d cycles", READ_TIMEOUT);
                end_in_failure();
            end
            @(negedge clk);
        end
        data = rd_data;
    endtask

    // one vector line, inputs held for one cycle
    task automatic apply_vector(input logic [7:0] op,
                                input glb_intr_pkg::cfg_addr_t addr,
                                input glb_intr_pkg::cfg_data_t data,
                                input logic [3*N-1:0] pulse,
                                input glb_intr_pkg::cfg_data_t exp_rd,
                                input logic exp_intr);
        glb_intr_pkg::cfg_data_t seen;
        if (op != "W" && op != "R" && op != "P" && op != "I") begin
            $display("unknown operation '%s' in the vector file", op);
            end_in_failure();
        end
        @(posedge clk);
        wr_en <= (op == "W");
        wr_addr <= addr;
        wr_data <= data;
        rd_en <= (op == "R");
        rd_addr <= addr;
        // pulses ride along with any operation
        event_pulse_bundle <= pulse;
        @(posedge clk);
        drive_idle();
        if (op == "R") begin
            wait_read_data(seen);
            check_rd_data(exp_rd, seen);
        end else begin
            @(negedge clk);
        end
        check_interrupt(exp_intr, interrupt);
    endtask

    task automatic run_vector_file();
        int fd;
        int fields;
        int line_no;
        string line;
        logic [7:0] op;
        glb_intr_pkg::cfg_addr_t v_addr;
        glb_intr_pkg::cfg_data_t v_data;
        logic [3*N-1:0] v_pulse;
        glb_intr_pkg::cfg_data_t v_rd;
        logic v_intr;
        fd = $fopen("tests/glb_intr_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/glb_intr_vectors.txt");
            end_in_failure();
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %h %h %h",
                             op, v_addr, v_data, v_pulse, v_rd, v_intr);
            if (fields != 6) begin
                $display("vector line %0d does not hold six fields", line_no);
                end_in_failure();
            end
            apply_vector(op, v_addr, v_data, v_pulse, v_rd, v_intr);
        end
        $fclose(fd);
    endtask

    // register value as software would read it, zero-extended
    function automatic glb_intr_pkg::cfg_data_t model_read(input glb_intr_pkg::cfg_addr_t addr);
        glb_intr_pkg::cfg_data_t value;
        value = '0;
        if (addr == ADDR_IER_DMA) begin
            value[2*N-1:0] = m_ier_dma;
        end else if (addr == ADDR_ISR_DMA) begin
            value[2*N-1:0] = m_isr_dma;
        end else if (addr == ADDR_IER_PCFG) begin
            value[N-1:0] = m_ier_pcfg;
        end else if (addr == ADDR_ISR_PCFG) begin
            value[N-1:0] = m_isr_pcfg;
        end
        return value;
    endfunction

    // apply the inputs the dut samples at this edge
    task automatic model_edge();
        logic dma_isr_wr;
        logic pcfg_isr_wr;
        logic [2*N-1:0] next_dma;
        logic [N-1:0] next_pcfg;
        // read sees the state from before this edge
        if (cur_rd_en) begin
            exp_reads.push_back(model_read(cur_rd_addr));
        end
        dma_isr_wr = cur_wr_en && (cur_wr_addr == ADDR_ISR_DMA);
        pcfg_isr_wr = cur_wr_en && (cur_wr_addr == ADDR_ISR_PCFG);
        // enabled event first, then a written one flips, else hold
        for (int b = 0; b < 2*N; b++) begin
            if (m_ier_dma[b] && cur_pulse[b]) begin
                next_dma[b] = 1'b1;
            end else if (dma_isr_wr && cur_wr_data[b]) begin
                next_dma[b] = ~m_isr_dma[b];
            end else begin
                next_dma[b] = m_isr_dma[b];
            end
        end
        for (int b = 0; b < N; b++) begin
            if (m_ier_pcfg[b] && cur_pulse[2*N+b]) begin
                next_pcfg[b] = 1'b1;
            end else if (pcfg_isr_wr && cur_wr_data[b]) begin
                next_pcfg[b] = ~m_isr_pcfg[b];
            end else begin
                next_pcfg[b] = m_isr_pcfg[b];
            end
        end
        m_isr_dma = next_dma;
        m_isr_pcfg = next_pcfg;
        // enables last, they gate only later events
        if (cur_wr_en && cur_wr_addr == ADDR_IER_DMA) begin
            m_ier_dma = cur_wr_data[2*N-1:0];
        end
        if (cur_wr_en && cur_wr_addr == ADDR_IER_PCFG) begin
            m_ier_pcfg = cur_wr_data[N-1:0];
        end
    endtask

    // mapped registers mostly, some unmapped or unaligned
    function automatic glb_intr_pkg::cfg_addr_t random_addr(input logic [31:0] r);
        glb_intr_pkg::cfg_addr_t addr;
        case (r[31:29])
            3'd0, 3'd1: addr = ADDR_ISR_DMA;
            3'd2:       addr = ADDR_IER_DMA;
            3'd3:       addr = ADDR_IER_PCFG;
            3'd4, 3'd5: addr = ADDR_ISR_PCFG;
            default:    addr = glb_intr_pkg::cfg_addr_t'(r >> 16);
        endcase
        return addr;
    endfunction

    task automatic pick_random_inputs();
        logic [31:0] r;
        r = next_random();
        cur_wr_en = (r[31:29] < 3'd3);
        // three reads in four, so many run back to back
        cur_rd_en = (r[28:27] != 2'b00);
        cur_wr_addr = random_addr(next_random());
        cur_wr_data = glb_intr_pkg::cfg_data_t'(next_random());
        cur_rd_addr = random_addr(next_random());
        // sparse pulses, about one bit in eight
        for (int b = 0; b < 3*N; b++) begin
            r = next_random();
            cur_pulse[b] = (r[31:29] == 3'b000);
        end
        wr_en <= cur_wr_en;
        wr_addr <= cur_wr_addr;
        wr_data <= cur_wr_data;
        rd_en <= cur_rd_en;
        rd_addr <= cur_rd_addr;
        event_pulse_bundle <= cur_pulse;
    endtask

    // exactly one valid per read, on the following cycle
    task automatic sample_outputs();
        glb_intr_pkg::cfg_data_t expected;
        check_read_valid(exp_reads.size() != 0, rd_data_valid);
        if (exp_reads.size() != 0) begin
            expected = exp_reads.pop_front();
            check_rd_data(expected, rd_data);
        end
        check_interrupt((|m_isr_dma) | (|m_isr_pcfg), interrupt);
    endtask

    task automatic run_random_phase();
        int waited;
        lcg_state = 32'h18dc0b5c;
        m_ier_dma = '0;
        m_isr_dma = '0;
        m_ier_pcfg = '0;
        m_isr_pcfg = '0;
        exp_reads.delete();
        cur_wr_en = 1'b0;
        cur_wr_addr = '0;
        cur_wr_data = '0;
        cur_rd_en = 1'b0;
        cur_rd_addr = '0;
        cur_pulse = '0;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            @(posedge clk);
            model_edge();
            pick_random_inputs();
            @(negedge clk);
            sample_outputs();
        end
        // last inputs go in, then the bus falls idle
        @(posedge clk);
        model_edge();
        drive_idle();
        waited = 0;
        while (exp_reads.size() != 0) begin
            waited++;
            if (waited > READ_TIMEOUT) begin
                $display("no read data came back after the random phase");
                end_in_failure();
            end
            @(negedge clk);
            sample_outputs();
        end
    endtask

    initial begin
        drive_idle();
        reset <= 1'b1;
        hold_reset();
        run_vector_file();
        // fresh reset so the model starts from all zeros
        @(posedge clk);
        reset <= 1'b1;
        hold_reset();
        run_random_phase();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/glb_intr_vectors.txt ====
# op addr data pulse exp_rd exp_intr, all hex, one bus cycle per line
# op: W write, R read, P pulse only, I idle; the pulse column applies on every op
# reset state of all four registers
R 000 00000000 000000 00000000 0
R 004 00000000 000000 00000000 0
R 008 00000000 000000 00000000 0
R 00C 00000000 000000 00000000 0
# unknown and unaligned addresses read as zero
R 010 00000000 000000 00000000 0
R 006 00000000 000000 00000000 0
R FFC 00000000 000000 00000000 0
# enable readback keeps only the low field
W 000 ABCD1234 000000 00000000 0
R 000 00000000 000000 00001234 0
W 008 5A5A5AC3 000000 00000000 0
R 008 00000000 000000 000000C3 0
R 000 00000000 000000 00001234 0
# enable store tile 0, load tile 0, config tile 2
W 000 00000101 000000 00000000 0
W 008 00000004 000000 00000000 0
R 000 00000000 000000 00000101 0
R 008 00000000 000000 00000004 0
# disabled store, load and config events set nothing
P 000 00000000 000002 00000000 0
P 000 00000000 000200 00000000 0
P 000 00000000 010000 00000000 0
I 000 00000000 000000 00000000 0
R 004 00000000 000000 00000000 0
R 00C 00000000 000000 00000000 0
# enabled store tile 0
P 000 00000000 000001 00000000 1
R 004 00000000 000000 00000001 1
# enabled load tile 0
P 000 00000000 000100 00000000 1
R 004 00000000 000000 00000101 1
# enabled config tile 2 with a disabled store tile 7
P 000 00000000 040080 00000000 1
R 00C 00000000 000000 00000004 1
R 004 00000000 000000 00000101 1
# a one clears, a zero holds
W 004 00000001 000000 00000000 1
R 004 00000000 000000 00000100 1
W 004 00000000 000000 00000000 1
R 004 00000000 000000 00000100 1
W 004 00000100 000000 00000000 1
R 004 00000000 000000 00000000 1
W 00C 00000004 000000 00000000 0
R 00C 00000000 000000 00000000 0
I 000 00000000 000000 00000000 0
# event beats a clearing write in the same cycle
P 000 00000000 000001 00000000 1
W 004 00000001 000001 00000000 1
R 004 00000000 000000 00000001 1
P 000 00000000 040000 00000000 1
W 00C 00000004 040000 00000000 1
R 00C 00000000 000000 00000004 1
# clear both banks, interrupt drops
W 004 00000001 000000 00000000 1
W 00C 00000004 000000 00000000 0
R 004 00000000 000000 00000000 0
R 00C 00000000 000000 00000000 0
# read returns the value from before a same-cycle pulse
R 004 00000000 000001 00000000 1
R 004 00000000 000000 00000001 1
W 004 00000001 000000 00000000 0
R 004 00000000 000000 00000000 0
